// File: hdl/l2_config.svh
/*
  Sizing for the L2 tag and state controller
  Tag width follows from these values
  L2_CREDITS must not exceed the three pipeline stages
*/
`ifndef L2_CONFIG_SVH
`define L2_CONFIG_SVH

// Physical address width
`define L2_ADDR_BITS 32

// Byte select within a 64 byte line
`define L2_OFFSET_BITS 6

// Set index bits for 16 sets
`define L2_INDEX_BITS 4

// Associativity
`define L2_WAYS 4

// Credits granted after reset match the pipeline depth
`define L2_CREDITS 3

`endif

// File: hdl/l2Pkg.sv
/*
  Shared types for the L2 controller pipeline
  snoopRespT encodings match the shared snoop bus (miss 0, hit 1, hitm 2)
*/
`include "l2_config.svh"

package l2Pkg;

  typedef logic [`L2_ADDR_BITS-`L2_INDEX_BITS-`L2_OFFSET_BITS-1:0] tagT;
  typedef logic [`L2_INDEX_BITS-1:0] indexT;
  typedef logic [$clog2(`L2_WAYS)-1:0] wayT;
  typedef logic [`L2_ADDR_BITS-1:0] addrT;

  // L1 requests first, snooped requests after
  typedef enum logic [2:0] {
    opDataRead        = 3'd0,
    opDataWrite       = 3'd1,
    opInstRead        = 3'd2,
    opSnoopRead       = 3'd3,
    opSnoopInvalidate = 3'd4,
    opSnoopRfo        = 3'd5
  } l2OpT;

  typedef enum logic [1:0] {mesiI, mesiS, mesiE, mesiM} mesiT;

  typedef enum logic [1:0] {busNone, busRd, busRdX, busUpgr} busOpT;

  typedef enum logic [1:0] {snoopMiss, snoopHit, snoopHitM} snoopRespT;

  // Sharers is the other caches' answer for our own miss
  typedef struct packed {
    l2OpT op;
    addrT address;
    logic sharers;
  } l2ReqT;

  typedef struct packed {
    l2OpT  op;
    tagT   tag;
    indexT index;
    logic  isSnoop;
    logic  isWrite;
    logic  sharers;
  } decodedReqT;

  typedef struct packed {
    l2OpT  op;
    tagT   tag;
    indexT index;
    logic  hit;
    wayT   way;
    mesiT  oldState;
    mesiT  newState;
    logic  victimDirty;
    tagT   victimTag;
  } execOutT;

  typedef struct packed {
    l2OpT      op;
    logic      hit;
    wayT       way;
    mesiT      newState;
    busOpT     busOp;
    snoopRespT snoopResp;
    logic      wbValid;
    addrT      wbAddress;
  } l2ResultT;

  // Snooped ops come from the shared bus, the rest from L1
  function automatic logic isSnoopOp(input l2OpT op);
    return (op == opSnoopRead) || (op == opSnoopInvalidate) || (op == opSnoopRfo);
  endfunction

endpackage

// File: hdl/l2RequestDecode.sv
/*
  First stage registers every cycle that reqValid is high
  The requester meters requests by credits, so no ready exists
  Offset bits of the address are ignored
*/
`timescale 1ns/1ns
`include "l2_config.svh"

module l2RequestDecode import l2Pkg::*; (
  input  logic       clk,
  input  logic       rstN,
  input  logic       reqValid,
  input  l2ReqT      req,
  output logic       decValid,
  output decodedReqT dec
);

  decodedReqT decNext;

  // ************************************************************
  // Address split and op classification
  // ************************************************************

  always_comb begin
    decNext.op    = req.op;
    // Tag is everything above index and byte select
    decNext.tag   = req.address[`L2_ADDR_BITS-1:`L2_OFFSET_BITS+`L2_INDEX_BITS];
    decNext.index = req.address[`L2_OFFSET_BITS +: `L2_INDEX_BITS];
    decNext.isSnoop = isSnoopOp(req.op);
    // Write-like ops end with the line owned or dropped
    decNext.isWrite = (req.op == opDataWrite) ||
                      (req.op == opSnoopInvalidate) ||
                      (req.op == opSnoopRfo);
    // Only meaningful on an L1 miss
    decNext.sharers = req.sharers;
  end

  // ************************************************************
  // Stage register
  // ************************************************************

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      decValid <= 1'b0;
    end else begin
      decValid <= reqValid;
    end
  end

  // Payload only loads on an accepted request
  always_ff @(posedge clk) begin
    if (reqValid) begin
      dec <= decNext;
    end
  end

endmodule

// File: hdl/l2LineExecute.sv
/*
  Second stage holds the tag, MESI state and LRU age arrays
  Arrays are read and written in one cycle, so same-set requests stay ordered
  Only L1 accesses install tags or move LRU ages
*/
`timescale 1ns/1ns
`include "l2_config.svh"

module l2LineExecute import l2Pkg::*; (
  input  logic       clk,
  input  logic       rstN,
  input  logic       decValid,
  input  decodedReqT dec,
  output logic       exValid,
  output execOutT    ex
);

  localparam int Sets = 1 << `L2_INDEX_BITS;
  localparam int Ways = `L2_WAYS;

  tagT  tagArr   [Sets][Ways];
  mesiT stateArr [Sets][Ways];
  wayT  ageArr   [Sets][Ways];

  logic [Ways-1:0] hitVec;
  logic            hit;
  logic            isL1;
  logic            foundInvalid;
  wayT             hitWay;
  wayT             victimWay;
  wayT             accessWay;
  wayT             maxAge;
  mesiT            oldState;
  mesiT            newState;
  execOutT         exNext;

  // ************************************************************
  // Hit detection
  // ************************************************************

  always_comb begin
    hitVec = '0;
    hitWay = '0;
    for (int w = 0; w < Ways; w++) begin
      // Invalid lines never hit, whatever their stale tag
      hitVec[w] = (tagArr[dec.index][w] == dec.tag) && (stateArr[dec.index][w] != mesiI);
    end
    // Lowest matching way wins
    for (int w = Ways - 1; w >= 0; w--) begin
      if (hitVec[w]) begin
        hitWay = wayT'(w);
      end
    end
  end

  assign hit  = |hitVec;
  assign isL1 = !dec.isSnoop;

  // ************************************************************
  // Victim choice
  // ************************************************************

  always_comb begin
    foundInvalid = 1'b0;
    victimWay    = '0;
    maxAge       = ageArr[dec.index][0];
    // First preference is the lowest invalid way
    for (int w = 0; w < Ways; w++) begin
      if (!foundInvalid && (stateArr[dec.index][w] == mesiI)) begin
        foundInvalid = 1'b1;
        victimWay    = wayT'(w);
      end
    end
    // Otherwise the oldest line
    if (!foundInvalid) begin
      for (int w = 1; w < Ways; w++) begin
        if (ageArr[dec.index][w] > maxAge) begin
          maxAge    = ageArr[dec.index][w];
          victimWay = wayT'(w);
        end
      end
    end
  end

  // ************************************************************
  // MESI transitions
  // ************************************************************

  always_comb begin
    accessWay = hit ? hitWay : victimWay;
    oldState  = hit ? stateArr[dec.index][hitWay] : mesiI;
    if (dec.isSnoop) begin
      if (!hit) begin
        newState = mesiI;
      end else if (dec.op == opSnoopRead) begin
        newState = mesiS;
      end else begin
        newState = mesiI;
      end
    end else if (dec.isWrite) begin
      newState = mesiM;
    end else if (hit) begin
      newState = oldState;
    end else begin
      // Read fill is shared if another cache answered
      newState = dec.sharers ? mesiS : mesiE;
    end
  end

  // States start invalid and ages start in way order
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int s = 0; s < Sets; s++) begin
        for (int w = 0; w < Ways; w++) begin
          stateArr[s][w] <= mesiI;
          ageArr[s][w]   <= wayT'(w);
        end
      end
    end else if (decValid) begin
      if (isL1) begin
        stateArr[dec.index][accessWay] <= newState;
        // Younger ways age by one and the accessed way becomes newest
        for (int w = 0; w < Ways; w++) begin
          if (ageArr[dec.index][w] < ageArr[dec.index][accessWay]) begin
            ageArr[dec.index][w] <= ageArr[dec.index][w] + 1'b1;
          end
        end
        ageArr[dec.index][accessWay] <= '0;
      end else if (hit) begin
        stateArr[dec.index][hitWay] <= newState;
      end
    end
  end

  // Fill installs the new tag over the victim
  always_ff @(posedge clk) begin
    if (decValid && isL1 && !hit) begin
      tagArr[dec.index][victimWay] <= dec.tag;
    end
  end

  // ************************************************************
  // Stage register
  // ************************************************************

  always_comb begin
    exNext.op    = dec.op;
    exNext.tag   = dec.tag;
    exNext.index = dec.index;
    exNext.hit   = hit;
    // Snoop misses touch no way
    exNext.way         = (hit || isL1) ? accessWay : '0;
    exNext.oldState    = oldState;
    exNext.newState    = newState;
    exNext.victimDirty = isL1 && !hit && (stateArr[dec.index][victimWay] == mesiM);
    exNext.victimTag   = tagArr[dec.index][victimWay];
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      exValid <= 1'b0;
    end else begin
      exValid <= decValid;
    end
  end

  always_ff @(posedge clk) begin
    if (decValid) begin
      ex <= exNext;
    end
  end

endmodule

// File: hdl/l2ResultStage.sv
/*
  Third stage forms the bus op, snoop answer, writeback and statistics
  One credit comes back with every result and the consumer takes all of them
  wbAddress reads zero when wbValid is low
*/
`timescale 1ns/1ns
`include "l2_config.svh"

module l2ResultStage import l2Pkg::*; (
  input  logic        clk,
  input  logic        rstN,
  input  logic        exValid,
  input  execOutT     ex,
  output logic        resValid,
  output logic        creditReturn,
  output l2ResultT    res,
  output logic [31:0] hitCount,
  output logic [31:0] missCount,
  output logic [31:0] readCount,
  output logic [31:0] writeCount
);

  logic     isSnoop;
  logic     isL1Read;
  logic     isL1Write;
  tagT      wbTag;
  l2ResultT resNext;

  assign isSnoop   = isSnoopOp(ex.op);
  assign isL1Read  = (ex.op == opDataRead) || (ex.op == opInstRead);
  assign isL1Write = (ex.op == opDataWrite);

  // A snoop flushes its own line and a fill flushes the victim
  assign wbTag = isSnoop ? ex.tag : ex.victimTag;

  // ************************************************************
  // Bus op, snoop answer and writeback
  // ************************************************************

  always_comb begin
    resNext.op       = ex.op;
    resNext.hit      = ex.hit;
    resNext.way      = ex.way;
    resNext.newState = ex.newState;

    if (isL1Read && !ex.hit) begin
      resNext.busOp = busRd;
    end else if (isL1Write && !ex.hit) begin
      resNext.busOp = busRdX;
    end else if (isL1Write && (ex.oldState == mesiS)) begin
      resNext.busOp = busUpgr;
    end else begin
      // Includes the silent E to M upgrade
      resNext.busOp = busNone;
    end

    resNext.snoopResp = snoopMiss;
    if (isSnoop) begin
      case (ex.oldState)
        mesiM:        resNext.snoopResp = snoopHitM;
        mesiE, mesiS: resNext.snoopResp = snoopHit;
        default:      resNext.snoopResp = snoopMiss;
      endcase
    end

    resNext.wbValid = (isSnoop && (ex.oldState == mesiM)) ||
                      (!isSnoop && !ex.hit && ex.victimDirty);
    resNext.wbAddress = resNext.wbValid ?
                        {wbTag, ex.index, {`L2_OFFSET_BITS{1'b0}}} : '0;
  end

  // ************************************************************
  // Output register and counters
  // ************************************************************

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      resValid   <= 1'b0;
      hitCount   <= '0;
      missCount  <= '0;
      readCount  <= '0;
      writeCount <= '0;
    end else begin
      resValid <= exValid;
      if (exValid) begin
        // Hit and miss count L1 traffic only
        if (!isSnoop && ex.hit) begin
          hitCount <= hitCount + 1'b1;
        end
        if (!isSnoop && !ex.hit) begin
          missCount <= missCount + 1'b1;
        end
        if (isL1Read) begin
          readCount <= readCount + 1'b1;
        end
        if (isL1Write) begin
          writeCount <= writeCount + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (exValid) begin
      res <= resNext;
    end
  end

  // Credit goes back as the result leaves
  assign creditReturn = resValid;

endmodule

// File: hdl/l2CacheTop.sv
/*
  L2 tag controller built as a three-stage pipeline
  Result appears three cycles after each accepted request
*/
`timescale 1ns/1ns

module l2CacheTop import l2Pkg::*; (
  input  logic        clk,
  input  logic        rstN,
  input  logic        reqValid,
  input  l2ReqT       req,
  output logic        resValid,
  output l2ResultT    res,
  output logic        creditReturn,
  output logic [31:0] hitCount,
  output logic [31:0] missCount,
  output logic [31:0] readCount,
  output logic [31:0] writeCount
);

  // Stage hand-offs
  logic       decValid;
  decodedReqT dec;
  logic       exValid;
  execOutT    ex;

  l2RequestDecode decodeStage (
    .clk(clk), .rstN(rstN),
    .reqValid(reqValid), .req(req),
    .decValid(decValid), .dec(dec)
  );

  l2LineExecute executeStage (
    .clk(clk), .rstN(rstN),
    .decValid(decValid), .dec(dec),
    .exValid(exValid), .ex(ex)
  );

  l2ResultStage resultStage (
    .clk(clk), .rstN(rstN),
    .exValid(exValid), .ex(ex),
    .resValid(resValid), .creditReturn(creditReturn), .res(res),
    .hitCount(hitCount), .missCount(missCount),
    .readCount(readCount), .writeCount(writeCount)
  );

endmodule

// File: verification/l2Cache_sva.sv
/*
  Protocol checks for the L2 controller, bound to the top level
  A credit comes back one cycle after creditReturn is seen
*/
`timescale 1ns/1ns
`include "l2_config.svh"

module l2CacheAssert (
  input logic clk,
  input logic rstN,
  input logic reqValid,
  input logic resValid,
  input logic creditReturn
);

  // Requests accepted and not yet answered
  logic [3:0] outstanding;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      outstanding <= '0;
    end else begin
      outstanding <= outstanding + reqValid - creditReturn;
    end
  end

  // ************************************************************
  // Protocol properties
  // ************************************************************

  creditWithinLimit: assert property (@(posedge clk) disable iff (!rstN)
    reqValid |-> (outstanding < `L2_CREDITS))
    else $error("Request sent with all credits in use");

  // The pipeline never stalls, so each result trails its request by three cycles
  resultLatency: assert property (@(posedge clk) disable iff (!rstN)
    resValid == $past(reqValid, 3))
    else $error("Result does not follow its request by three cycles");

  creditWithResult: assert property (@(posedge clk)
    creditReturn == resValid)
    else $error("Credit return differs from result valid");

  quietInReset: assert property (@(posedge clk)
    !rstN |-> (!resValid && !creditReturn))
    else $error("Output valid while in reset");

endmodule

bind l2CacheTop l2CacheAssert sva (
  .clk(clk),
  .rstN(rstN),
  .reqValid(reqValid),
  .resValid(resValid),
  .creditReturn(creditReturn)
);

// File: verification/l2CacheTb.sv
/*
  Testbench for the L2 tag controller against a reference model of tags, states and ages
  Requests are metered by a local credit count and results are taken at the falling edge
  Channel timing is left to the bound assertions
*/
`timescale 1ns/1ns
`include "l2_config.svh"

module l2CacheTb import l2Pkg::*; ();

  localparam int Sets      = 1 << `L2_INDEX_BITS;
  localparam int Ways      = `L2_WAYS;
  localparam int WaitLimit = 50;

  logic        clk;
  logic        rstN;
  logic        reqValid;
  l2ReqT       req;
  logic        resValid;
  l2ResultT    res;
  logic        creditReturn;
  logic [31:0] hitCount;
  logic [31:0] missCount;
  logic [31:0] readCount;
  logic [31:0] writeCount;

  // Reference model of tags, states, ages and counters
  tagT         mTag   [Sets][Ways];
  mesiT        mState [Sets][Ways];
  int          mAge   [Sets][Ways];
  logic [31:0] mHit;
  logic [31:0] mMiss;
  logic [31:0] mRead;
  logic [31:0] mWrite;
  l2ResultT    expQ [$];

  int   seed;
  int   credits;
  int   errCount;
  int   checked;
  logic aborted;

  l2CacheTop uut (
    .clk(clk), .rstN(rstN),
    .reqValid(reqValid), .req(req),
    .resValid(resValid), .res(res), .creditReturn(creditReturn),
    .hitCount(hitCount), .missCount(missCount),
    .readCount(readCount), .writeCount(writeCount)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic addrT makeAddr(input tagT t, input indexT ix);
    return {t, ix, {`L2_OFFSET_BITS{1'b0}}};
  endfunction

  task automatic reportMismatch(input string name, input logic [31:0] expVal,
                                input logic [31:0] actVal);
    errCount++;
    $display("ERR %0t %s expected %0h actual %0h", $time, name, expVal, actVal);
  endtask

  // ************************************************************
  // Reference model
  // ************************************************************

  task automatic predict(input l2OpT op, input addrT addr, input logic sh);
    l2ResultT e;
    tagT      t;
    indexT    ix;
    int       hw;
    int       vw;
    int       aw;
    int       accAge;
    logic     isSn;
    logic     hit;
    mesiT     oldS;
    mesiT     newS;
    t    = addr[`L2_ADDR_BITS-1:`L2_OFFSET_BITS+`L2_INDEX_BITS];
    ix   = addr[`L2_OFFSET_BITS +: `L2_INDEX_BITS];
    isSn = op inside {opSnoopRead, opSnoopInvalidate, opSnoopRfo};
    hw   = -1;
    vw   = -1;
    // Find the lowest valid way with a matching tag and the lowest invalid way
    for (int w = Ways - 1; w >= 0; w--) begin
      if (mState[ix][w] != mesiI && mTag[ix][w] == t) hw = w;
      if (mState[ix][w] == mesiI) vw = w;
    end
    // Full set evicts the oldest way
    if (vw < 0) begin
      vw = 0;
      for (int w = 1; w < Ways; w++) begin
        if (mAge[ix][w] > mAge[ix][vw]) vw = w;
      end
    end
    hit  = (hw >= 0);
    oldS = hit ? mState[ix][hw] : mesiI;
    if (isSn) begin
      newS = (hit && op == opSnoopRead) ? mesiS : mesiI;
    end else if (op == opDataWrite) begin
      newS = mesiM;
    end else begin
      newS = hit ? oldS : (sh ? mesiS : mesiE);
    end

    e.op       = op;
    e.hit      = hit;
    e.way      = hit ? wayT'(hw) : (isSn ? '0 : wayT'(vw));
    e.newState = newS;
    e.busOp    = busNone;
    if (!isSn && !hit) e.busOp = (op == opDataWrite) ? busRdX : busRd;
    if (op == opDataWrite && hit && oldS == mesiS) e.busOp = busUpgr;
    e.snoopResp = snoopMiss;
    if (isSn && oldS == mesiM) e.snoopResp = snoopHitM;
    if (isSn && (oldS == mesiS || oldS == mesiE)) e.snoopResp = snoopHit;
    e.wbValid   = isSn ? (oldS == mesiM) : (!hit && mState[ix][vw] == mesiM);
    e.wbAddress = '0;
    if (e.wbValid) e.wbAddress = makeAddr(isSn ? t : mTag[ix][vw], ix);

    if (!isSn) begin
      if (hit) mHit++;
      else mMiss++;
      aw     = hit ? hw : vw;
      accAge = mAge[ix][aw];
      mState[ix][aw] = newS;
      mTag[ix][aw]   = t;
      // Younger ways age and the accessed way becomes newest
      for (int w = 0; w < Ways; w++) begin
        if (mAge[ix][w] < accAge) mAge[ix][w]++;
      end
      mAge[ix][aw] = 0;
    end else if (hit) begin
      mState[ix][hw] = newS;
    end
    if (op == opDataRead || op == opInstRead) mRead++;
    if (op == opDataWrite) mWrite++;
    expQ.push_back(e);
  endtask

  // ************************************************************
  // Stimulus and result checks
  // ************************************************************

  // Called 1 ns after a rising edge and returns 1 ns after the next one
  task automatic issue(input l2OpT op, input addrT addr, input logic sh);
    int waited;
    waited = 0;
    if (aborted) return;
    while (credits == 0 && waited < WaitLimit) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (credits == 0) begin
      errCount++;
      aborted = 1'b1;
      $display("Timeout: no credit came back within %0d cycles", WaitLimit);
      return;
    end
    req.op      = op;
    req.address = addr;
    req.sharers = sh;
    reqValid    = 1'b1;
    credits--;
    predict(op, addr, sh);
    @(posedge clk);
    #1;
    reqValid = 1'b0;
  endtask

  task automatic compareResult();
    l2ResultT e;
    if (expQ.size() == 0) begin
      errCount++;
      $display("Result at %0t arrived with no request outstanding", $time);
      return;
    end
    e = expQ.pop_front();
    checked++;
    assert (res.op == e.op) else reportMismatch("res.op", e.op, res.op);
    assert (res.hit == e.hit) else reportMismatch("res.hit", e.hit, res.hit);
    assert (res.way == e.way) else reportMismatch("res.way", e.way, res.way);
    assert (res.newState == e.newState)
      else reportMismatch("res.newState", e.newState, res.newState);
    assert (res.busOp == e.busOp) else reportMismatch("res.busOp", e.busOp, res.busOp);
    assert (res.snoopResp == e.snoopResp)
      else reportMismatch("res.snoopResp", e.snoopResp, res.snoopResp);
    assert (res.wbValid == e.wbValid)
      else reportMismatch("res.wbValid", e.wbValid, res.wbValid);
    assert (res.wbAddress == e.wbAddress)
      else reportMismatch("res.wbAddress", e.wbAddress, res.wbAddress);
  endtask

  // Results are stable mid-cycle
  always @(negedge clk) begin
    if (rstN && creditReturn) credits++;
    if (rstN && resValid) compareResult();
  end

  task automatic drainResults();
    int waited;
    waited = 0;
    if (aborted) return;
    while (expQ.size() != 0 && waited < WaitLimit) begin
      @(posedge clk);
      waited++;
    end
    if (expQ.size() != 0) begin
      errCount++;
      aborted = 1'b1;
      $display("Timeout: %0d results still missing", expQ.size());
    end
  endtask

  initial begin
    int rnd;
    seed     = 47930;
    errCount = 0;
    checked  = 0;
    aborted  = 1'b0;
    credits  = `L2_CREDITS;
    mHit     = '0;
    mMiss    = '0;
    mRead    = '0;
    mWrite   = '0;
    rstN     = 1'b0;
    reqValid = 1'b0;
    req      = '0;
    for (int s = 0; s < Sets; s++) begin
      for (int w = 0; w < Ways; w++) begin
        mTag[s][w]   = '0;
        mState[s][w] = mesiI;
        mAge[s][w]   = w;
      end
    end
    repeat (8) @(posedge clk);
    #1;
    rstN = 1'b1;
    @(posedge clk);
    #1;

    // Read miss to E, read hit, shared instruction fill
    issue(opDataRead, makeAddr(22'h100, 4'd1), 1'b0);
    issue(opDataRead, makeAddr(22'h100, 4'd1), 1'b0);
    issue(opInstRead, makeAddr(22'h101, 4'd1), 1'b1);
    // Silent E to M, upgrade from S, write miss
    issue(opDataWrite, makeAddr(22'h100, 4'd1), 1'b0);
    issue(opDataWrite, makeAddr(22'h101, 4'd1), 1'b0);
    issue(opDataWrite, makeAddr(22'h200, 4'd2), 1'b0);
    // Snoop on M flushes, invalidate on S, then a miss, snoop on an absent line
    issue(opSnoopRead, makeAddr(22'h200, 4'd2), 1'b0);
    issue(opSnoopInvalidate, makeAddr(22'h200, 4'd2), 1'b0);
    issue(opDataRead, makeAddr(22'h200, 4'd2), 1'b1);
    issue(opSnoopRfo, makeAddr(22'h3ff, 4'd3), 1'b0);
    // Fill one set with dirty lines, reuse two, then evict twice
    for (int i = 0; i < 4; i++) begin
      issue(opDataWrite, makeAddr(tagT'(22'h10 + i), 4'd5), 1'b0);
    end
    issue(opDataRead, makeAddr(22'h10, 4'd5), 1'b0);
    issue(opDataRead, makeAddr(22'h12, 4'd5), 1'b0);
    issue(opDataWrite, makeAddr(22'h14, 4'd5), 1'b0);
    issue(opInstRead, makeAddr(22'h15, 4'd5), 1'b1);
    // Random traffic at full credit use over a small tag range for reuse
    for (int i = 0; i < 300; i++) begin
      l2OpT  op;
      tagT   t;
      indexT ix;
      rnd = $random(seed);
      op  = l2OpT'($unsigned(rnd) % 6);
      t   = tagT'(($unsigned(rnd) >> 4) % 8);
      ix  = indexT'(($unsigned(rnd) >> 8) % 4);
      issue(op, makeAddr(t, ix), rnd[12]);
    end
    drainResults();

    if (!aborted) begin
      @(posedge clk);
      #1;
      assert (hitCount == mHit) else reportMismatch("hitCount", mHit, hitCount);
      assert (missCount == mMiss) else reportMismatch("missCount", mMiss, missCount);
      assert (readCount == mRead) else reportMismatch("readCount", mRead, readCount);
      assert (writeCount == mWrite) else reportMismatch("writeCount", mWrite, writeCount);
    end

    $display("errors %0d, results checked %0d", errCount, checked);
    if (errCount == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: build.f
+incdir+hdl
hdl/l2Pkg.sv
hdl/l2RequestDecode.sv
hdl/l2LineExecute.sv
hdl/l2ResultStage.sv
hdl/l2CacheTop.sv
verification/l2Cache_sva.sv
verification/l2CacheTb.sv

// File: run.sh
#!/bin/sh
# Builds the L2 controller testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
    --top-module l2CacheTb -Mdir obj_dir -f build.f; then
  echo "Verilator build failed"
  exit 1
fi

simOut=$(./obj_dir/Vl2CacheTb)
simStatus=$?
printf '%s\n' "$simOut"

if [ "$simStatus" -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

if printf '%s\n' "$simOut" | grep -qx "sim passed"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
